// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_width     = words_per_line * word_width;   // 128
    localparam int num_sets       = 64;                            // default only
    localparam int index_width    = $clog2(num_sets);
    localparam int offset_width   = 4;
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int strb_width     = word_width / 8;

    localparam int word_sel_width = $clog2(words_per_line);
    localparam int byte_sel_width = offset_width - word_sel_width;

    // one address word, seen as a flat byte address or as lookup fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]      tag;
            logic [index_width-1:0]    index;
            logic [word_sel_width-1:0] word_sel;
            logic [byte_sel_width-1:0] byte_off;
        } fields;
    } dcache_addr_u;

endpackage

// ==== hdl/dcache_ifs.sv ====
`timescale 1ns/1ns

interface tag_port_if import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) ();
    localparam int iw = $clog2(num_sets);
    localparam int tw = addr_width - iw - offset_width;

    logic [iw-1:0]      index;      // read and write share the index
    logic [tw-1:0]      cmp_tag;
    logic [1:0]         wr_way;
    logic [tw-1:0]      wr_tag;
    logic               wr_dirty;   // 0 on refill, 1 on store hit

    logic [1:0]         hit;
    logic [1:0]         dirty;
    logic [1:0][tw-1:0] rd_tag;

    modport controller (
        output index, cmp_tag, wr_way, wr_tag, wr_dirty,
        input  hit, dirty, rd_tag
    );
    modport array (
        input  index, cmp_tag, wr_way, wr_tag, wr_dirty,
        output hit, dirty, rd_tag
    );
endinterface

interface data_port_if import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) ();
    localparam int iw = $clog2(num_sets);

    logic                               rd_en;
    logic [iw-1:0]                      rd_index;
    logic [iw-1:0]                      wr_index;
    logic [1:0][words_per_line-1:0]     wr_en;      // per way, per word
    logic [line_width-1:0]              wr_line;
    logic [1:0][line_width-1:0]         rd_line;

    modport controller (output rd_en, rd_index, wr_index, wr_en, wr_line, input rd_line);
    modport array (input rd_en, rd_index, wr_index, wr_en, wr_line, output rd_line);
endinterface

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  dcache_addr_u                req_addr,
    input  logic [word_width-1:0]       req_wdata,
    input  logic [strb_width-1:0]       req_wstrb,
    output logic                        busy,
    output logic                        rdata_valid,
    output logic [word_width-1:0]       rdata,
    tag_port_if.controller              tag,
    data_port_if.controller             data,
    input  logic                        victim_way,
    output logic [$clog2(num_sets)-1:0] plru_index,
    output logic                        hit_stb,
    output logic                        refill_stb,
    output logic                        way,
    output logic                        mem_rd_req,
    output logic [addr_width-1:0]       mem_rd_addr,
    input  logic                        mem_rd_rdy,
    input  logic                        mem_ret_valid,
    input  logic [line_width-1:0]       mem_ret_data,
    output logic                        mem_wr_req,
    output logic [addr_width-1:0]       mem_wr_addr,
    output logic [line_width-1:0]       mem_wr_data,
    input  logic                        mem_wr_rdy,
    input  logic                        mem_wr_done
);
    localparam int iw = $clog2(num_sets);
    localparam int tw = addr_width - iw - offset_width;

    localparam logic [2:0] s_lookup  = 3'd0;
    localparam logic [2:0] s_wb_req  = 3'd1;
    localparam logic [2:0] s_wb_wait = 3'd2;
    localparam logic [2:0] s_rf_req  = 3'd3;
    localparam logic [2:0] s_rf_wait = 3'd4;
    localparam logic [2:0] s_rf_done = 3'd5;

    logic [2:0]            state, next_state;
    logic                  r_valid;
    logic                  r_write;
    dcache_addr_u          r_addr;
    logic [word_width-1:0] r_wdata;
    logic [strb_width-1:0] r_wstrb;
    logic                  vway;        // victim latched at miss
    logic [iw-1:0]         r_index, lk_index;
    logic [tw-1:0]         r_tag;
    logic                  accept, lookup, hit_any, hit_way, miss, store_hit, refill_land;
    logic [word_width-1:0] rd_word, merged;

    assign r_index     = r_addr.raw[offset_width +: iw];
    assign r_tag       = r_addr.raw[addr_width-1 -: tw];
    assign lookup      = (state == s_lookup) & r_valid;
    assign hit_any     = |tag.hit;
    assign hit_way     = tag.hit[1];
    assign miss        = lookup & ~hit_any;
    assign store_hit   = lookup & hit_any & r_write;
    assign refill_land = (state == s_rf_wait) & mem_ret_valid;

    // a store hit costs one busy cycle for the merge write
    assign busy   = (state != s_lookup) | (r_valid & (r_write | ~hit_any));
    assign accept = req_valid & ~busy;

    assign rd_word     = data.rd_line[hit_way][r_addr.fields.word_sel*word_width +: word_width];
    assign rdata       = rd_word;
    assign rdata_valid = lookup & hit_any & ~r_write;

    always_comb begin
        for (int b = 0; b < strb_width; b++) begin
            merged[b*8 +: 8] = r_wstrb[b] ? r_wdata[b*8 +: 8] : rd_word[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            r_valid <= 1'b0;
        else if (accept)
            r_valid <= 1'b1;
        else if (lookup & hit_any)
            r_valid <= 1'b0;    // done, nothing new behind it
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_write <= req_write;
            r_addr  <= req_addr;
            r_wdata <= req_wdata;
            r_wstrb <= req_wstrb;
        end
        if (miss)
            vway <= victim_way;
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= s_lookup;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            s_lookup:  if (miss) next_state = tag.dirty[victim_way] ? s_wb_req : s_rf_req;
            s_wb_req:  if (mem_wr_rdy) next_state = s_wb_wait;
            s_wb_wait: if (mem_wr_done) next_state = s_rf_req;
            s_rf_req:  if (mem_rd_rdy) next_state = s_rf_wait;
            s_rf_wait: if (mem_ret_valid) next_state = s_rf_done;
            s_rf_done: next_state = s_lookup;   // repeat lookup
            default:   next_state = s_lookup;
        endcase
    end

    // new request reads the arrays at its own index, else hold the current one
    assign lk_index      = accept ? req_addr.raw[offset_width +: iw] : r_index;
    assign tag.index     = lk_index;
    assign tag.cmp_tag   = accept ? req_addr.raw[addr_width-1 -: tw] : r_tag;
    assign tag.wr_tag    = r_tag;
    assign tag.wr_dirty  = store_hit;

    assign data.rd_en    = accept | (state == s_rf_done);
    assign data.rd_index = lk_index;
    assign data.wr_index = r_index;
    assign data.wr_line  = refill_land ? mem_ret_data : {words_per_line{merged}};

    always_comb begin
        tag.wr_way = '0;
        data.wr_en = '0;
        if (refill_land) begin
            tag.wr_way[vway] = 1'b1;
            data.wr_en[vway] = '1;
        end else if (store_hit) begin
            tag.wr_way[hit_way] = 1'b1;
            data.wr_en[hit_way][r_addr.fields.word_sel] = 1'b1;
        end
    end

    assign plru_index = r_index;
    assign hit_stb    = lookup & hit_any;
    assign refill_stb = refill_land;
    assign way        = refill_land ? vway : hit_way;

    assign mem_rd_req  = (state == s_rf_req);
    assign mem_rd_addr = {r_tag, r_index, {offset_width{1'b0}}};
    assign mem_wr_req  = (state == s_wb_req);
    assign mem_wr_addr = {tag.rd_tag[vway], r_index, {offset_width{1'b0}}};
    assign mem_wr_data = data.rd_line[vway];    // array output holds during the miss

    // a line lives in at most one way of its set
    a_one_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(tag.hit));

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req));

endmodule

// ==== hdl/dcache_tag_array.sv ====
`timescale 1ns/1ns

module dcache_tag_array import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) (
    input  logic      clk,
    input  logic      reset,
    tag_port_if.array port
);
    localparam int iw = $clog2(num_sets);
    localparam int tw = addr_width - iw - offset_width;

    logic [tw-1:0]            tags [2][num_sets];
    logic [1:0][num_sets-1:0] valid_bits;
    logic [1:0][num_sets-1:0] dirty_bits;

    logic [1:0][tw-1:0] rd_tag_q;
    logic [1:0]         rd_valid;
    logic [tw-1:0]      cmp_q;      // compare tag, one cycle behind like the read

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (port.wr_way[w])
                tags[w][port.index] <= port.wr_tag;
            rd_tag_q[w] <= tags[w][port.index];
        end
        cmp_q <= port.cmp_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            rd_valid   <= '0;
            port.dirty <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (port.wr_way[w]) begin
                    valid_bits[w][port.index] <= 1'b1;
                    dirty_bits[w][port.index] <= port.wr_dirty;
                end
                rd_valid[w]   <= valid_bits[w][port.index];
                port.dirty[w] <= dirty_bits[w][port.index];
            end
        end
    end

    assign port.rd_tag = rd_tag_q;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            port.hit[w] = rd_valid[w] & (rd_tag_q[w] == cmp_q);
        end
    end

    a_one_way_write: assert property (@(posedge clk) disable iff (reset)
        !(port.wr_way[0] && port.wr_way[1]));

endmodule

// ==== hdl/dcache_data_array.sv ====
`timescale 1ns/1ns

module dcache_data_array import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) (
    input  logic       clk,
    data_port_if.array port
);
    logic [words_per_line-1:0][word_width-1:0] lines [2][num_sets];

    // word granular writes for store merges, all words on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < words_per_line; k++) begin
                if (port.wr_en[w][k])
                    lines[w][port.wr_index][k] <= port.wr_line[k*word_width +: word_width];
            end
        end
    end

    // output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            for (int w = 0; w < 2; w++) begin
                port.rd_line[w] <= lines[w][port.rd_index];
            end
        end
    end

endmodule

// ==== hdl/dcache_plru.sv ====
`timescale 1ns/1ns

module dcache_plru #(
    parameter int num_sets = dcache_pkg::num_sets
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [$clog2(num_sets)-1:0] index,
    input  logic                        hit_stb,
    input  logic                        refill_stb,
    input  logic                        way,
    output logic                        victim_way
);
    logic [num_sets-1:0] next_victim;   // one bit per set

    always_ff @(posedge clk) begin
        if (reset)
            next_victim <= '0;
        else if (hit_stb | refill_stb)
            next_victim[index] <= ~way;     // point away from the way just used
    end

    assign victim_way = next_victim[index];

endmodule

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; #(
    parameter int num_sets = dcache_pkg::num_sets
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [addr_width-1:0] req_addr,
    input  logic [word_width-1:0] req_wdata,
    input  logic [strb_width-1:0] req_wstrb,
    output logic                  busy,
    output logic [word_width-1:0] rdata,
    output logic                  rdata_valid,
    output logic                  mem_rd_req,
    output logic [addr_width-1:0] mem_rd_addr,
    input  logic                  mem_rd_rdy,
    input  logic                  mem_ret_valid,
    input  logic [line_width-1:0] mem_ret_data,
    output logic                  mem_wr_req,
    output logic [addr_width-1:0] mem_wr_addr,
    output logic [line_width-1:0] mem_wr_data,
    input  logic                  mem_wr_rdy,
    input  logic                  mem_wr_done
);
    logic [$clog2(num_sets)-1:0] plru_index;
    logic                        hit_stb, refill_stb, way, victim_way;

    tag_port_if  #(.num_sets(num_sets)) tag_if ();
    data_port_if #(.num_sets(num_sets)) data_if ();

    dcache_ctrl #(.num_sets(num_sets)) u_ctrl (
        .clk, .reset,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_wstrb,
        .busy, .rdata_valid, .rdata,
        .tag(tag_if.controller), .data(data_if.controller),
        .victim_way, .plru_index, .hit_stb, .refill_stb, .way,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_data,
        .mem_wr_req, .mem_wr_addr, .mem_wr_data, .mem_wr_rdy, .mem_wr_done
    );

    dcache_tag_array #(.num_sets(num_sets)) u_tag (
        .clk, .reset, .port(tag_if.array)
    );

    dcache_data_array #(.num_sets(num_sets)) u_data (
        .clk, .port(data_if.array)
    );

    dcache_plru #(.num_sets(num_sets)) u_plru (
        .clk, .reset, .index(plru_index), .hit_stb, .refill_stb, .way, .victim_way
    );

endmodule

// ==== test/tb_dcache_model.svh ====
// backing memory the DUT refills from, and the reference with every accepted store
localparam int mem_words = 4096;    // tags 0..15 over all 64 sets

logic [31:0] ref_mem [mem_words];
logic [31:0] mem     [mem_words];
logic [21:0] res_tag    [2][64];    // resident lines as the PLRU rules predict
logic        res_valid  [2][64];
logic        res_dirty  [2][64];
logic        res_victim [64];

function automatic logic [31:0] fill_pattern(int unsigned i);
    return (i * 32'h9e37_79b1) ^ (i << 19) ^ 32'h5ac3_0f1e;
endfunction

function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                            logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
        if (strb[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
endfunction

function automatic logic [127:0] ref_line(logic [31:0] addr);
    logic [127:0] l;
    for (int k = 0; k < 4; k++)
        l[k*32 +: 32] = ref_mem[addr[13:4]*4 + k];
    return l;
endfunction

function automatic logic [127:0] mem_line(logic [31:0] addr);
    logic [127:0] l;
    for (int k = 0; k < 4; k++)
        l[k*32 +: 32] = mem[addr[13:4]*4 + k];
    return l;
endfunction

// one accepted request: traffic it should cause, store merge or expected load word
task automatic cache_model(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb);
    logic [5:0]  idx;
    logic [21:0] tg;
    int          w;
    idx = addr[9:4];
    tg  = addr[31:10];
    w   = -1;
    for (int k = 0; k < 2; k++) begin
        if (res_valid[k][idx] && res_tag[k][idx] == tg)
            w = k;
    end
    if (w < 0) begin
        w = res_victim[idx];
        if (res_dirty[w][idx])
            exp_wr_cnt++;   // dirty victim goes back first
        exp_rd_cnt++;
        res_tag[w][idx]   = tg;
        res_valid[w][idx] = 1'b1;
        res_dirty[w][idx] = 1'b0;
    end
    if (wr) begin
        res_dirty[w][idx]   = 1'b1;
        ref_mem[addr[13:2]] = merge_bytes(ref_mem[addr[13:2]], wdata, strb);
    end else
        exp_data.push_back(ref_mem[addr[13:2]]);
    res_victim[idx] = (w == 0);
endtask

task automatic init_model();
    for (int i = 0; i < mem_words; i++) begin
        mem[i]     = fill_pattern(i);
        ref_mem[i] = fill_pattern(i);
    end
    for (int s = 0; s < 64; s++) begin
        res_victim[s] = 1'b0;
        for (int k = 0; k < 2; k++) begin
            res_tag[k][s]   = '0;
            res_valid[k][s] = 1'b0;
            res_dirty[k][s] = 1'b0;
        end
    end
endtask

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache import dcache_pkg::*; ();
    logic                  clk, reset;
    logic                  req_valid, req_write;
    logic [addr_width-1:0] req_addr;
    logic [word_width-1:0] req_wdata;
    logic [strb_width-1:0] req_wstrb;
    logic                  busy, rdata_valid;
    logic [word_width-1:0] rdata;
    logic                  mem_rd_req, mem_rd_rdy, mem_ret_valid;
    logic                  mem_wr_req, mem_wr_rdy, mem_wr_done;
    logic [addr_width-1:0] mem_rd_addr, mem_wr_addr;
    logic [line_width-1:0] mem_ret_data, mem_wr_data;

    int unsigned  err_count, test_err0, tests_passed, tests_failed;
    int unsigned  rd_cnt, wr_cnt, exp_rd_cnt, exp_wr_cnt;
    logic [31:0]  exp_data [$];
    logic [31:0]  mon_exp, rd_line_addr, wr_line_addr;
    logic [127:0] wr_line;
    int           rd_phase, rd_wait, wr_phase, wr_wait;

    `include "tb_dcache_model.svh"

    dcache_top #(.num_sets(64)) DUT (.*);

    always #50 clk = ~clk;

    // load responses in acceptance order
    always @(negedge clk) begin
        if (!reset && rdata_valid) begin
            if (exp_data.size() == 0) begin
                $display("rdata_valid came with no load outstanding at %0t", $time);
                err_count++;
            end else begin
                mon_exp = exp_data.pop_front();
                if (rdata !== mon_exp) begin
                    $display("ERR %0t: load data %08h, expected %08h", $time, rdata, mon_exp);
                    err_count++;
                end
            end
        end
    end

    // memory side with random ready and done delays
    always @(negedge clk) begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        if (!reset) begin
            if (rd_phase == 0 && mem_rd_req) begin
                rd_cnt++;
                rd_line_addr = mem_rd_addr;
                if (mem_rd_addr[3:0] != 0 || mem_rd_addr >= mem_words * 4) begin
                    $display("ERR %0t: refill address %08h is misaligned or out of range",
                             $time, mem_rd_addr);
                    err_count++;
                end
                rd_wait  = $urandom_range(5, 0);
                rd_phase = 1;
            end
            if (rd_phase == 1) begin
                if (rd_wait == 0) begin
                    mem_rd_rdy = 1'b1;
                    rd_wait    = $urandom_range(5, 0);
                    rd_phase   = 2;
                end else
                    rd_wait--;
            end else if (rd_phase == 2) begin
                if (rd_wait == 0) begin
                    mem_ret_valid = 1'b1;
                    mem_ret_data  = mem_line(rd_line_addr);
                    rd_phase      = 0;
                end else
                    rd_wait--;
            end
            if (wr_phase == 0 && mem_wr_req) begin
                wr_cnt++;
                wr_line_addr = mem_wr_addr;
                wr_line      = mem_wr_data;
                if (mem_wr_data !== ref_line(mem_wr_addr)) begin
                    $display("ERR %0t: write-back line at %08h differs from the model",
                             $time, mem_wr_addr);
                    err_count++;
                end
                wr_wait  = $urandom_range(5, 0);
                wr_phase = 1;
            end
            if (wr_phase == 1) begin
                if (wr_wait == 0) begin
                    mem_wr_rdy = 1'b1;
                    wr_wait    = $urandom_range(5, 0);
                    wr_phase   = 2;
                end else
                    wr_wait--;
            end else if (wr_phase == 2) begin
                if (wr_wait == 0) begin
                    mem_wr_done = 1'b1;
                    for (int k = 0; k < 4; k++)
                        mem[wr_line_addr[13:4]*4 + k] = wr_line[k*32 +: 32];
                    wr_phase = 0;
                end else
                    wr_wait--;
            end
        end
    end

    function automatic logic [31:0] make_addr(int unsigned t, int unsigned i, int unsigned w);
        return (t << 10) | (i << 4) | (w << 2);
    endfunction

    task automatic timeout_abort(input string what);
        $display("timed out at %0t waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > 200)
                timeout_abort("busy to fall");
        end
    endtask

    // returns at the falling edge after acceptance
    task automatic issue(input logic wr, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] strb);
        int n;
        n = 0;
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > 200)
                timeout_abort("request acceptance");
        end
        cache_model(wr, addr, wdata, strb);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        wait_idle();
        @(negedge clk);
        if (exp_data.size() != 0) begin
            $display("%0d loads never returned data", exp_data.size());
            exp_data.delete();
            err_count++;
        end
        if (rd_cnt != exp_rd_cnt || wr_cnt != exp_wr_cnt) begin
            $display("ERR %0t: %0d refills and %0d write-backs, expected %0d and %0d",
                     $time, rd_cnt, wr_cnt, exp_rd_cnt, exp_wr_cnt);
            err_count++;
        end
        if (err_count == test_err0) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, err_count - test_err0);
        end
        test_err0 = err_count;
    endtask

    initial begin
        logic [31:0] a;
        int unsigned r0, w0;
        void'($urandom(67241));
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        mem_rd_rdy = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data = '0;
        mem_wr_rdy = 1'b0;
        mem_wr_done = 1'b0;
        {err_count, test_err0, tests_passed, tests_failed} = '0;
        {rd_cnt, wr_cnt, exp_rd_cnt, exp_wr_cnt} = '0;
        rd_phase = 0;
        wr_phase = 0;
        init_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 8; i++) begin
            a  = make_addr(0, i * 3, $urandom_range(3, 0));
            r0 = rd_cnt;
            issue(1'b0, a, '0, '0);
            wait_idle();
            if (rd_cnt != r0 + 1 || rd_line_addr != {a[31:4], 4'h0}) begin
                $display("ERR %0t: load %08h gave %0d refills, last at %08h",
                         $time, a, rd_cnt - r0, rd_line_addr);
                err_count++;
            end
        end
        end_test(1, "cold loads");

        r0 = rd_cnt;
        w0 = wr_cnt;
        for (int i = 0; i < 16; i++) begin
            issue(1'b0, make_addr(0, $urandom_range(7, 0) * 3, $urandom_range(3, 0)), '0, '0);
            if (!rdata_valid || busy) begin
                $display("ERR %0t: hit did not answer one cycle after acceptance", $time);
                err_count++;
            end
        end
        if (rd_cnt != r0 || wr_cnt != w0) begin
            $display("ERR %0t: memory traffic during hits", $time);
            err_count++;
        end
        end_test(2, "back-to-back hits");

        for (int i = 0; i < 12; i++) begin
            a = make_addr($urandom_range(1, 0), $urandom_range(7, 0) * 3, $urandom_range(3, 0));
            issue(1'b1, a, $urandom, $urandom_range(15, 0));
            issue(1'b0, a, '0, '0);
        end
        end_test(3, "store merge");

        issue(1'b1, make_addr(4, 40, 1), $urandom, $urandom_range(15, 1));
        issue(1'b0, make_addr(5, 40, 2), '0, '0);
        wait_idle();
        w0 = wr_cnt;
        issue(1'b0, make_addr(6, 40, 0), '0, '0);    // evicts the dirty line
        wait_idle();
        if (wr_cnt != w0 + 1 || wr_line_addr != make_addr(4, 40, 0)) begin
            $display("ERR %0t: third fill gave %0d write-backs, last at %08h",
                     $time, wr_cnt - w0, wr_line_addr);
            err_count++;
        end
        issue(1'b0, make_addr(4, 40, 1), '0, '0);
        wait_idle();
        if (wr_cnt != w0 + 1) begin
            $display("ERR %0t: clean victim was written back", $time);
            err_count++;
        end
        end_test(4, "set conflict eviction");

        for (int i = 0; i < 400; i++) begin
            a = make_addr($urandom_range(3, 0), $urandom_range(7, 0), $urandom_range(3, 0));
            issue($urandom_range(1, 0), a, $urandom, $urandom_range(15, 0));
            if ($urandom_range(3, 0) == 0)
                repeat ($urandom_range(3, 1)) @(negedge clk);
        end
        for (int s = 0; s < 64; s++) begin
            issue(1'b0, make_addr(12, s, 0), '0, '0);
            issue(1'b0, make_addr(13, s, 0), '0, '0);
        end
        wait_idle();
        @(negedge clk);
        for (int i = 0; i < mem_words; i++) begin
            if (mem[i] !== ref_mem[i]) begin
                $display("ERR %0t: memory word %0d is %08h, expected %08h",
                         $time, i, mem[i], ref_mem[i]);
                err_count++;
            end
        end
        end_test(5, "random mix");

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+test
hdl/dcache_pkg.sv
hdl/dcache_ifs.sv
hdl/dcache_ctrl.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_plru.sv
hdl/dcache_top.sv
test/tb_dcache.sv
